/* testbench/frame_ctrl_vectors.mem */
// kind[31:28] chn[27:24] arg[23:0]; kind 2 (arg = seq) is followed by its 22-bit payload
// kinds: 1 mode, 2 status, 3 page_ready count, 4 frame_done, 5 line_unfinished, 6 outside
10000001
30000005
50000123
20000011
0014048d
40000000
20000012
0014048e
11000003
31000013
5100abcd
12000004
32000002
5200ffff
13000005
53000007
60000007
61000105
20000021
0014048e
21000022
000eaf35
22000023
000bfffc
23000024
0000001d
12000000
13000002
43000000
230000f0
0000001e
21000031
000eaf35
30000011
20000032
0018048e
f0000000

/* flist.f */
source/mcntrl_pkg.sv
source/cmd_deser.sv
source/status_packet.sv
source/frame_channel.sv
source/status_router.sv
source/mcntrl_frame_ctrl.sv
testbench/tb_mcntrl_frame_ctrl.sv

/* Bender.yml */
package:
  name: mcntrl_frame_ctrl

sources:
  - source/mcntrl_pkg.sv
  - source/cmd_deser.sv
  - source/status_packet.sv
  - source/frame_channel.sv
  - source/status_router.sv
  - source/mcntrl_frame_ctrl.sv
  - target: test
    files:
      - testbench/tb_mcntrl_frame_ctrl.sv

/* testbench/tb_mcntrl_frame_ctrl.sv */
// Testbench for the four-channel frame control block.
// Reads testbench/frame_ctrl_vectors.mem, run from the project root.
// Keeps its own page/busy/finished model to cross-check the vector payloads.
// Inputs change 2 ns after the rising edge; outputs are sampled at the same point.
`timescale 1ns/1ps

module tb_mcntrl_frame_ctrl import mcntrl_pkg::*; ();

    localparam int        fh_bits   = 16;
    localparam int        max_vec   = 64;
    localparam bus_addr_t in_addr   = 16'h00f0;
    localparam bus_addr_t stat_addr = 16'h7cf0;   // in window, high bits masked off
    localparam bus_addr_t out_addr  = 16'h0130;

    logic               mclk;
    logic               rst;
    cmd_byte_t          cmd_ad;
    logic               cmd_stb;
    cmd_byte_t          status_ad;
    logic               status_rq;
    logic               status_start;
    logic [num_chn-1:0] frame_start;
    logic [num_chn-1:0] next_page;
    logic [num_chn-1:0] suspend;
    logic [num_chn-1:0] page_ready;
    logic [num_chn-1:0] frame_done;
    logic [fh_bits-1:0] line_unfinished [num_chn];

    logic [31:0] vec [max_vec];
    int          num_vec;
    int          errors;
    int          test_no;
    int          tests_passed;
    int          tests_failed;
    logic [31:0] lcg_state;

    page_t              m_page [num_chn];     // channel model
    logic [fh_bits-1:0] m_line [num_chn];
    logic [num_chn-1:0] m_busy;
    logic [num_chn-1:0] m_fin;
    logic [num_chn-1:0] m_susp;

    int          q_ch[$];                     // packets still expected
    seq_t        q_seq[$];
    logic [31:0] q_pay[$];
    bit          q_bad[$];

    mcntrl_frame_ctrl #(
        .frame_height_bits (fh_bits)
    ) DUT (
        .mclk            (mclk),
        .rst             (rst),
        .cmd_ad          (cmd_ad),
        .cmd_stb         (cmd_stb),
        .status_ad       (status_ad),
        .status_rq       (status_rq),
        .status_start    (status_start),
        .frame_start     (frame_start),
        .next_page       (next_page),
        .suspend         (suspend),
        .page_ready      (page_ready),
        .frame_done      (frame_done),
        .line_unfinished (line_unfinished)
    );

    initial mclk = 1'b0;
    always #10 mclk = ~mclk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int rand_below(input int n);
        lcg_state = lcg_next(lcg_state);
        return int'(lcg_state[31:16]) % n;
    endfunction

    // busy, finished, line count, page from bit 0 upward
    function automatic logic [31:0] model_payload(input int ch);
        logic [31:0] p;
        p                        = '0;
        p[0]                     = m_busy[ch];
        p[1]                     = m_fin[ch];
        p[fh_bits+1:2]           = m_line[ch];
        p[fh_bits+5:fh_bits+2]   = m_page[ch];
        return p;
    endfunction

    task automatic step();
        @(posedge mclk);
        #2;
    endtask

    task automatic report_err(input string msg);
        errors++;
        $display("ERR %0t: %s", $time, msg);
    endtask

    task automatic end_test(input string what, input bit failed);
        test_no++;
        if (failed) begin
            tests_failed++;
            $display("test %0d %s: mismatch", test_no, what);
        end else begin
            tests_passed++;
            $display("test %0d %s: ok", test_no, what);
        end
    endtask

    // strobe with address low, then address high, then data
    task automatic send_cmd(input bus_addr_t addr, input cmd_byte_t data);
        repeat (rand_below(3)) step();
        cmd_stb = 1'b1;
        cmd_ad  = addr[7:0];
        step();
        cmd_stb = 1'b0;
        cmd_ad  = addr[15:8];
        step();
        cmd_ad = data;
        step();
        cmd_ad = '0;                              // now at t+3, cmd_we high
    endtask

    task automatic check_cmd(input int ch, input cmd_byte_t data, input bit applies);
        logic [num_chn-1:0] exp_fs;
        logic [num_chn-1:0] exp_np;
        exp_fs = '0;
        exp_np = '0;
        if (applies) begin
            exp_fs[ch] = data[bit_frame_start];
            exp_np[ch] = data[bit_next_page];
        end
        if (frame_start !== '0 || next_page !== '0)
            report_err("pulse seen before t+4");
        if (suspend !== m_susp)
            report_err("suspend changed before t+4");
        step();
        if (applies)
            m_susp[ch] = data[bit_suspend];
        if (frame_start !== exp_fs)
            report_err($sformatf("frame_start %b, expected %b", frame_start, exp_fs));
        if (next_page !== exp_np)
            report_err($sformatf("next_page %b, expected %b", next_page, exp_np));
        if (suspend !== m_susp)
            report_err($sformatf("suspend %b, expected %b", suspend, m_susp));
        step();
        if (frame_start !== '0 || next_page !== '0)
            report_err("pulse longer than one cycle");
        if (suspend !== m_susp)
            report_err($sformatf("suspend %b did not hold, expected %b", suspend, m_susp));
        if (status_rq !== 1'b0)
            report_err("status_rq high without a status write");
        if (applies && data[bit_frame_start]) begin
            m_page[ch] = '0;
            m_busy[ch] = 1'b1;
            m_fin[ch]  = 1'b0;
        end
    endtask

    // take every outstanding packet, in whatever order the router grants
    task automatic drain_packets();
        int        n;
        int        idx;
        int        err0;
        cmd_byte_t addr;
        cmd_byte_t got [4];
        cmd_byte_t exp [4];
        logic [31:0] p;
        while (q_ch.size() > 0) begin
            n = 0;
            while (status_rq !== 1'b1 && n < 60) begin
                step();
                n++;
            end
            if (status_rq !== 1'b1) begin
                $display("no status request from the DUT within 60 cycles, %0d packets missing",
                         q_ch.size());
                errors       += q_ch.size();
                tests_failed += q_ch.size();
                q_ch.delete();
                q_seq.delete();
                q_pay.delete();
                q_bad.delete();
                return;
            end
            err0 = errors;
            repeat (rand_below(4)) begin
                step();
                if (status_rq !== 1'b1)
                    report_err("status_rq dropped before status_start");
            end
            addr = status_ad;
            idx  = -1;
            for (int k = 0; k < q_ch.size(); k++)
                if (addr == cmd_byte_t'(status_addr_base + q_ch[k]))
                    idx = k;
            status_start = 1'b1;
            step();
            status_start = 1'b0;
            for (int k = 0; k < 4; k++) begin
                got[k] = status_ad;
                if (status_rq !== 1'b0)
                    report_err("status_rq high during packet bytes");
                if (k < 3)
                    step();
            end
            if (idx < 0) begin
                report_err($sformatf("unexpected packet address byte %02h", addr));
                end_test("status packet", 1'b1);
            end else begin
                p      = q_pay[idx];
                exp[0] = {q_seq[idx], p[1:0]};
                exp[1] = p[9:2];
                exp[2] = p[17:10];
                exp[3] = p[25:18];
                for (int k = 0; k < 4; k++)
                    if (got[k] !== exp[k])
                        report_err($sformatf("chn %0d byte %0d is %02h, expected %02h",
                                             q_ch[idx], k + 1, got[k], exp[k]));
                end_test($sformatf("status chn %0d seq %02h", q_ch[idx], q_seq[idx]),
                         q_bad[idx] || errors != err0);
                q_ch.delete(idx);
                q_seq.delete(idx);
                q_pay.delete(idx);
                q_bad.delete(idx);
            end
        end
    endtask

    initial begin
        int          i;
        int          kind;
        int          ch;
        int          err0;
        logic [31:0] w;
        logic [31:0] exp_pay;
        logic [31:0] mod_pay;
        rst          = 1'b1;
        cmd_ad       = '0;
        cmd_stb      = 1'b0;
        status_start = 1'b0;
        page_ready   = '0;
        frame_done   = '0;
        m_busy       = '0;
        m_fin        = '0;
        m_susp       = '0;
        for (int k = 0; k < num_chn; k++) begin
            line_unfinished[k] = '0;
            m_line[k]          = '0;
            m_page[k]          = '0;
        end
        lcg_state    = 32'ha93e_ac5e;
        errors       = 0;
        test_no      = 0;
        tests_passed = 0;
        tests_failed = 0;
        for (int k = 0; k < max_vec; k++)
            vec[k] = 32'hf000_0000;           // end marker
        $readmemh("testbench/frame_ctrl_vectors.mem", vec);
        while (num_vec < max_vec && vec[num_vec][31:28] != 4'hf)
            num_vec++;

        repeat (2) @(posedge mclk);
        #2;
        rst = 1'b0;
        step();
        if (frame_start !== '0 || next_page !== '0 || suspend !== '0 || status_rq !== 1'b0)
            report_err("outputs not low after reset");
        end_test("reset values", errors != 0);

        if (num_vec == 0) begin
            $display("vector file missing or empty");
            errors++;
        end
        i = 0;
        while (i < num_vec) begin
            w    = vec[i];
            kind = int'(w[31:28]);
            ch   = int'(w[27:24]) % num_chn;
            err0 = errors;
            i++;
            case (kind)
                1: begin
                    send_cmd(in_addr | bus_addr_t'(2 * ch + 2), w[7:0]);
                    check_cmd(ch, w[7:0], 1'b1);
                    end_test($sformatf("mode chn %0d data %02h", ch, w[7:0]), errors != err0);
                end
                2: begin
                    exp_pay = vec[i];
                    i++;
                    mod_pay = model_payload(ch);
                    if (exp_pay !== mod_pay)
                        report_err($sformatf("vector payload %06h, model gives %06h",
                                             exp_pay, mod_pay));
                    send_cmd(stat_addr | bus_addr_t'(2 * ch + 3), w[7:0]);
                    q_ch.push_back(ch);
                    q_seq.push_back(w[5:0]);
                    q_pay.push_back(exp_pay);
                    q_bad.push_back(errors != err0);
                    if (i >= num_vec || vec[i][31:28] != 4'd2)
                        drain_packets();
                end
                3: begin
                    for (int n = 0; n < int'(w[7:0]); n++) begin
                        page_ready[ch] = 1'b1;
                        step();
                        page_ready[ch] = 1'b0;
                        step();
                    end
                    m_page[ch] = m_page[ch] + page_t'(w[7:0]);    // wraps at 16
                    end_test($sformatf("page_ready chn %0d x%0d", ch, w[7:0]), errors != err0);
                end
                4: begin
                    frame_done[ch] = 1'b1;
                    step();
                    frame_done[ch] = 1'b0;
                    step();
                    m_busy[ch] = 1'b0;
                    m_fin[ch]  = 1'b1;
                    end_test($sformatf("frame_done chn %0d", ch), errors != err0);
                end
                5: begin
                    line_unfinished[ch] = w[fh_bits-1:0];
                    m_line[ch]          = w[fh_bits-1:0];
                    step();
                    end_test($sformatf("line_unfinished chn %0d", ch), errors != err0);
                end
                6: begin
                    send_cmd(out_addr | bus_addr_t'(2 * ch + (w[8] ? 3 : 2)), w[7:0]);
                    check_cmd(ch, w[7:0], 1'b0);
                    end_test($sformatf("outside write chn %0d", ch), errors != err0);
                end
                default: begin
                    $display("vector %0d has unknown kind %0d", i - 1, kind);
                    errors++;
                end
            endcase
        end

        $display("tests: %0d passed, %0d failed", tests_passed, tests_failed);
        if (errors == 0 && tests_failed == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

    // watchdog scaled by vector count
    initial begin
        wait (num_vec > 0);
        repeat (num_vec * 60) @(posedge mclk);
        $display("timeout: run did not finish within %0d cycles", num_vec * 60);
        $display("Result: FAILED");
        $finish;
    end

endmodule

/* source/mcntrl_frame_ctrl.sv */
// Frame memory controller control block, four channels.
// Commands: strobe with address low byte, then address high and data bytes.
// Status: downstream may pulse status_start only while status_rq is high.
// frame_height_bits up to 20 so the payload fits in four status bytes.
`timescale 1ns/1ps

module mcntrl_frame_ctrl import mcntrl_pkg::*; #(
    parameter bus_addr_t cmd_base_addr     = 16'h00f0,
    parameter bus_addr_t cmd_addr_mask     = 16'h03f0,
    parameter int        frame_height_bits = 16
) (
    input  logic                         mclk,
    input  logic                         rst,
    input  cmd_byte_t                    cmd_ad,
    input  logic                         cmd_stb,
    output cmd_byte_t                    status_ad,
    output logic                         status_rq,
    input  logic                         status_start,
    output logic [num_chn-1:0]           frame_start,
    output logic [num_chn-1:0]           next_page,
    output logic [num_chn-1:0]           suspend,
    input  logic [num_chn-1:0]           page_ready,
    input  logic [num_chn-1:0]           frame_done,
    input  logic [frame_height_bits-1:0] line_unfinished [num_chn]
);

    logic               cmd_we;
    cmd_addr_t          cmd_a;
    cmd_byte_t          cmd_data;
    cmd_byte_t          chn_ad [num_chn];
    logic [num_chn-1:0] chn_rq;
    logic [num_chn-1:0] chn_start;

    cmd_deser #(
        .cmd_base_addr (cmd_base_addr),
        .cmd_addr_mask (cmd_addr_mask)
    ) u_cmd_deser (
        .mclk     (mclk),
        .rst      (rst),
        .cmd_ad   (cmd_ad),
        .cmd_stb  (cmd_stb),
        .cmd_we   (cmd_we),
        .cmd_a    (cmd_a),
        .cmd_data (cmd_data)
    );

    for (genvar k = 0; k < num_chn; k++) begin : g_chn
        frame_channel #(
            .chn_index         (k),
            .frame_height_bits (frame_height_bits)
        ) u_chn (
            .mclk            (mclk),
            .rst             (rst),
            .cmd_we          (cmd_we),
            .cmd_a           (cmd_a),
            .cmd_data        (cmd_data),
            .page_ready      (page_ready[k]),
            .frame_done      (frame_done[k]),
            .line_unfinished (line_unfinished[k]),
            .frame_start     (frame_start[k]),
            .next_page       (next_page[k]),
            .suspend         (suspend[k]),
            .status_ad       (chn_ad[k]),
            .status_rq       (chn_rq[k]),
            .status_start    (chn_start[k])
        );
    end

    status_router #(
        .num_chn (num_chn)
    ) u_router (
        .mclk         (mclk),
        .rst          (rst),
        .rq_in        (chn_rq),
        .ad_in        (chn_ad),
        .start_in     (chn_start),
        .status_ad    (status_ad),
        .status_rq    (status_rq),
        .status_start (status_start)
    );

endmodule

/* source/status_router.sv */
// Round-robin merge of per-channel status packets onto one byte stream.
// Grant is registered, data path is combinational from the granted channel.
// Grant stays locked until the last packet byte after start.
`timescale 1ns/1ps

module status_router import mcntrl_pkg::*; #(
    parameter int num_chn = 4
) (
    input  logic               mclk,
    input  logic               rst,
    input  logic [num_chn-1:0] rq_in,
    input  cmd_byte_t          ad_in [num_chn],
    output logic [num_chn-1:0] start_in,
    output cmd_byte_t          status_ad,
    output logic               status_rq,
    input  logic               status_start
);

    localparam int sel_bits = (num_chn > 1) ? $clog2(num_chn) : 1;
    localparam int cnt_bits = $clog2(pkt_bytes);

    typedef logic [sel_bits-1:0] sel_t;

    arb_state_t          state;
    sel_t                sel;          // current or last winner
    sel_t                next_sel;
    logic                found;
    logic [cnt_bits-1:0] byte_cnt;     // 0 while waiting for start

    // search starts just after the last winner
    always_comb begin
        int cand;
        next_sel = sel;
        found    = 1'b0;
        for (int i = 1; i <= num_chn; i++) begin
            cand = (int'(sel) + i) % num_chn;
            if (!found && rq_in[cand]) begin
                next_sel = sel_t'(cand);
                found    = 1'b1;
            end
        end
    end

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            state    <= arb_idle;
            sel      <= sel_t'(num_chn - 1);    // channel 0 wins first
            byte_cnt <= '0;
        end else begin
            unique case (state)
                arb_idle: begin
                    if (found) begin
                        sel   <= next_sel;
                        state <= arb_locked;
                    end
                end
                arb_locked: begin
                    if (status_start) begin
                        byte_cnt <= cnt_bits'(1);
                    end else if (byte_cnt == cnt_bits'(pkt_bytes - 1)) begin
                        byte_cnt <= '0;
                        state    <= arb_idle;    // rearbitrate after last byte
                    end else if (byte_cnt != '0) begin
                        byte_cnt <= byte_cnt + 1'b1;
                    end
                end
                default: state <= arb_idle;
            endcase
        end
    end

    assign status_ad = ad_in[sel];
    assign status_rq = (state == arb_locked) && rq_in[sel];

    always_comb begin
        start_in = '0;
        if (state == arb_locked)
            start_in[sel] = status_start;
    end

    // downstream acknowledges only a raised request
    a_start_on_rq: assert property (@(posedge mclk) disable iff (rst)
        status_start |-> status_rq);

endmodule

/* source/frame_channel.sv */
// One channel: mode register, control pulses, page counter, frame flags.
// Command codes are derived from chn_index.
// Status-control data bits 7:6 are ignored; only the sequence number is used.
`timescale 1ns/1ps

module frame_channel import mcntrl_pkg::*; #(
    parameter int chn_index         = 0,
    parameter int frame_height_bits = 16
) (
    input  logic                         mclk,
    input  logic                         rst,
    input  logic                         cmd_we,
    input  cmd_addr_t                    cmd_a,
    input  cmd_byte_t                    cmd_data,
    input  logic                         page_ready,
    input  logic                         frame_done,
    input  logic [frame_height_bits-1:0] line_unfinished,
    output logic                         frame_start,
    output logic                         next_page,
    output logic                         suspend,
    output cmd_byte_t                    status_ad,
    output logic                         status_rq,
    input  logic                         status_start
);

    localparam cmd_addr_t mode_code   = cmd_addr_t'(mode_code_base + 2 * chn_index);
    localparam cmd_addr_t status_code = cmd_addr_t'(status_code_base + 2 * chn_index);

    logic  set_mode;
    logic  status_we;
    seq_t  seq;
    page_t page;
    logic  busy;
    logic  finished;
    logic [frame_height_bits+$bits(page_t)+1:0] payload;

    assign set_mode  = cmd_we && (cmd_a == mode_code);
    assign status_we = cmd_we && (cmd_a == status_code);
    assign seq       = cmd_data[$bits(seq_t)-1:0];
    assign payload   = {page, line_unfinished, finished, busy};

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            frame_start <= 1'b0;
            next_page   <= 1'b0;
            suspend     <= 1'b0;
        end else begin
            frame_start <= set_mode && cmd_data[bit_frame_start];
            next_page   <= set_mode && cmd_data[bit_next_page];
            if (set_mode)
                suspend <= cmd_data[bit_suspend];    // level, held until next mode write
        end
    end

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            page     <= '0;
            busy     <= 1'b0;
            finished <= 1'b0;
        end else begin
            if (frame_start)
                page <= '0;
            else if (page_ready)
                page <= page + 1'b1;            // wraps at 16

            if (frame_start && !frame_done) begin
                busy     <= 1'b1;
                finished <= 1'b0;
            end else if (!frame_start && frame_done) begin
                busy     <= 1'b0;
                finished <= 1'b1;
            end
        end
    end

    status_packet #(
        .chn_index         (chn_index),
        .frame_height_bits (frame_height_bits)
    ) u_status (
        .mclk      (mclk),
        .rst       (rst),
        .status_we (status_we),
        .seq       (seq),
        .payload   (payload),
        .start     (status_start),
        .ad        (status_ad),
        .rq        (status_rq)
    );

endmodule

/* source/status_packet.sv */
// Builds one five-byte status packet per status write.
// No back-pressure once start is seen: bytes 1-4 go out on consecutive edges.
// A write during transmission is dropped; while pending it replaces the data.
`timescale 1ns/1ps

module status_packet import mcntrl_pkg::*; #(
    parameter int chn_index         = 0,
    parameter int frame_height_bits = 16
) (
    input  logic                                       mclk,
    input  logic                                       rst,
    input  logic                                       status_we,
    input  seq_t                                       seq,
    input  logic [frame_height_bits+$bits(page_t)+1:0] payload,
    input  logic                                       start,
    output cmd_byte_t                                  ad,
    output logic                                       rq
);

    localparam int        payload_bits = frame_height_bits + $bits(page_t) + 2;
    localparam int        word_bits    = 8 * (pkt_bytes - 1);
    localparam int        ext_bits     = word_bits - $bits(seq_t);
    localparam cmd_byte_t addr_byte    = cmd_byte_t'(status_addr_base + chn_index);

    pkt_state_t              state;
    logic [2:0]              byte_idx;     // byte number being sent, 1..4
    seq_t                    seq_r;
    logic [payload_bits-1:0] payload_r;
    logic [ext_bits-1:0]     payload_ext;
    logic [word_bits-1:0]    word;

    always_comb begin
        payload_ext                   = '0;
        payload_ext[payload_bits-1:0] = payload_r;
    end

    // byte1 = {seq, payload[1:0]}, then payload upward
    assign word = {payload_ext[ext_bits-1:2], seq_r, payload_ext[1:0]};
    assign rq   = (state == pending);

    always_comb begin
        if (state == sending)
            ad = word[8 * (int'(byte_idx) - 1) +: 8];
        else
            ad = addr_byte;
    end

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            state    <= idle;
            byte_idx <= 3'd0;
        end else begin
            unique case (state)
                idle: begin
                    if (status_we)
                        state <= pending;
                end
                pending: begin
                    if (start) begin
                        state    <= sending;
                        byte_idx <= 3'd1;
                    end
                end
                sending: begin
                    if (byte_idx == 3'(pkt_bytes - 1))
                        state <= idle;
                    byte_idx <= byte_idx + 3'd1;
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge mclk) begin
        if (status_we && ((state == idle) || (state == pending && !start))) begin
            seq_r     <= seq;
            payload_r <= payload;
        end
    end

    // router must only acknowledge a pending request
    a_start_rq: assert property (@(posedge mclk) disable iff (rst) start |-> rq);

endmodule

/* source/cmd_deser.sv */
// Collects three-byte commands: address low, address high, data.
// The strobe comes with the first byte only; a new strobe must wait
// until the previous command has been fully collected.
`timescale 1ns/1ps

module cmd_deser import mcntrl_pkg::*; #(
    parameter bus_addr_t cmd_base_addr = 16'h00f0,
    parameter bus_addr_t cmd_addr_mask = 16'h03f0
) (
    input  logic      mclk,
    input  logic      rst,
    input  cmd_byte_t cmd_ad,
    input  logic      cmd_stb,
    output logic      cmd_we,
    output cmd_addr_t cmd_a,
    output cmd_byte_t cmd_data
);

    logic [1:0] byte_cnt;     // 0 when waiting for strobe
    bus_addr_t  addr_sr;
    logic       addr_match;

    assign addr_match = ((addr_sr ^ cmd_base_addr) & cmd_addr_mask) == '0;

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            byte_cnt <= 2'd0;
            cmd_we   <= 1'b0;
        end else begin
            cmd_we <= 1'b0;
            if (cmd_stb) begin
                byte_cnt <= 2'd1;
            end else if (byte_cnt == 2'd1) begin
                byte_cnt <= 2'd2;
            end else if (byte_cnt == 2'd2) begin
                byte_cnt <= 2'd0;
                cmd_we   <= addr_match;    // only in-window commands
            end
        end
    end

    always_ff @(posedge mclk) begin
        if (cmd_stb)
            addr_sr[7:0] <= cmd_ad;
        if (byte_cnt == 2'd1)
            addr_sr[15:8] <= cmd_ad;
        if (byte_cnt == 2'd2) begin
            cmd_a    <= addr_sr[$bits(cmd_addr_t)-1:0];
            cmd_data <= cmd_ad;
        end
    end

    // host must not start a new command mid-collection
    a_stb_idle: assert property (@(posedge mclk) disable iff (rst)
        cmd_stb |-> (byte_cnt == 2'd0));

endmodule

/* source/mcntrl_pkg.sv */
// Shared widths, types and command codes for the frame control block.
// Command and status codes are per channel and follow from the channel index.
// Payload must fit in four status bytes, so frame height is limited to 20 bits.
package mcntrl_pkg;

    localparam int num_chn          = 4;
    localparam int mode_code_base   = 2;      // chn k mode code is 2k+2
    localparam int status_code_base = 3;      // chn k status code is 2k+3
    localparam int status_addr_base = 'h3c;   // packet address byte base
    localparam int pkt_bytes        = 5;      // address + four data bytes

    // mode data bits
    localparam int bit_frame_start = 0;
    localparam int bit_next_page   = 1;
    localparam int bit_suspend     = 2;

    typedef logic [7:0]  cmd_byte_t;
    typedef logic [3:0]  cmd_addr_t;
    typedef logic [15:0] bus_addr_t;
    typedef logic [3:0]  page_t;
    typedef logic [5:0]  seq_t;

    typedef enum logic [1:0] {
        idle,
        pending,
        sending
    } pkt_state_t;

    typedef enum logic {
        arb_idle,
        arb_locked
    } arb_state_t;

endpackage
